// ==== verilog/nice_pkg.sv ====
////////////////////
// nice accelerator shared definitions
// widths, custom-3 instruction codes and state encodings
////////////////////
`default_nettype none

package nice_pkg;

   // data and address width
   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [xlen-1:0] addr_t;

   ////////////////////
   // instruction encoding
   ////////////////////

   // custom-3 major opcode, r-type only
   localparam logic [6:0] opcode_custom3 = 7'b1111011;

   // lbuf and sbuf share one funct3
   localparam logic [2:0] funct3_buf    = 3'b010;
   localparam logic [2:0] funct3_rowsum = 3'b110;

   localparam logic [6:0] funct7_lbuf   = 7'b0000001;
   localparam logic [6:0] funct7_sbuf   = 7'b0000010;
   localparam logic [6:0] funct7_rowsum = 7'b0000110;

   // operation held for the whole instruction
   typedef enum logic [1:0] {
      op_lbuf,
      op_sbuf,
      op_rowsum
   } nice_op_e;

   // controller states
   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_resp
   } ctrl_state_e;

   ////////////////////
   // memory bus
   ////////////////////
   // size code 2 means a full 32-bit word
   localparam logic [1:0] icb_size_word = 2'b10;
   // address step between row elements
   localparam int word_bytes = 4;

endpackage

`default_nettype wire

// ==== verilog/nice_buf_if.sv ====
////////////////////
// row buffer access between controller and row storage
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface nice_buf_if
   import nice_pkg::*;
#(
   parameter int buf_depth = 4
) ();

   // one index bit minimum for a single-entry buffer
   localparam int idx_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;

   // controller side strobes
   logic             wr_en;
   logic             acc_en;
   logic             sum_clr;
   logic [idx_w-1:0] idx;
   logic [idx_w-1:0] rd_idx;
   word_t            wdata;

   // buffer side results
   word_t            rd_data;
   word_t            sum;
   logic             acc_busy;

   modport ctrl (output wr_en, acc_en, sum_clr, idx, rd_idx, wdata,
                 input  rd_data, sum, acc_busy);

   modport buffer (input  wr_en, acc_en, sum_clr, idx, rd_idx, wdata,
                   output rd_data, sum, acc_busy);

endinterface

`default_nettype wire

// ==== verilog/nice_ctrl.sv ====
////////////////////
// nice controller
// decode, idle/run/resp FSM, memory command issue and processor response
////////////////////
`timescale 1ns/1ps
`default_nettype none

module nice_ctrl
   import nice_pkg::*;
#(
   parameter int row_len   = 3,
   parameter int buf_depth = 4
) (
   input  logic       nice_clk,
   input  logic       nice_rst_n,
   output logic       nice_active,
   output logic       nice_mem_holdup,
   input  logic       nice_req_valid,
   output logic       nice_req_ready,
   input  word_t      nice_req_inst,
   input  word_t      nice_req_rs1,
   output logic       nice_rsp_valid,
   input  logic       nice_rsp_ready,
   output word_t      nice_rsp_rdat,
   output logic       nice_rsp_err,
   output logic       nice_icb_cmd_valid,
   input  logic       nice_icb_cmd_ready,
   output addr_t      nice_icb_cmd_addr,
   output logic       nice_icb_cmd_read,
   output word_t      nice_icb_cmd_wdata,
   output logic [1:0] nice_icb_cmd_size,
   input  logic       nice_icb_rsp_valid,
   output logic       nice_icb_rsp_ready,
   input  word_t      nice_icb_rsp_rdata,
   input  logic       nice_icb_rsp_err,
   nice_buf_if.ctrl   buf_if
);

   localparam int idx_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;
   // counters run 0..row_len
   localparam int cnt_w = $clog2(row_len + 1);
   localparam logic [cnt_w-1:0] cnt_end    = cnt_w'(row_len);
   localparam logic [cnt_w-1:0] cnt_end_m1 = cnt_w'(row_len - 1);

   ctrl_state_e      state;
   nice_op_e         op_r;
   nice_op_e         req_op;
   addr_t            addr_r;
   logic [cnt_w-1:0] cmd_cnt;
   logic [cnt_w-1:0] rsp_cnt;
   logic             err_r;
   logic [6:0]       opcode;
   logic [2:0]       funct3;
   logic [6:0]       funct7;
   logic             is_lbuf;
   logic             is_sbuf;
   logic             is_rowsum;
   logic             accept;
   logic             cmd_hs;
   logic             run_rsp_hs;
   logic             rsp_hs;
   logic             rsp_last;
   logic             rowsum_fin;

   ////////////////////
   // decode
   ////////////////////
   assign opcode = nice_req_inst[6:0];
   assign funct3 = nice_req_inst[14:12];
   assign funct7 = nice_req_inst[31:25];

   assign is_lbuf   = (opcode == opcode_custom3) && (funct3 == funct3_buf)
                      && (funct7 == funct7_lbuf);
   assign is_sbuf   = (opcode == opcode_custom3) && (funct3 == funct3_buf)
                      && (funct7 == funct7_sbuf);
   assign is_rowsum = (opcode == opcode_custom3) && (funct3 == funct3_rowsum)
                      && (funct7 == funct7_rowsum);

   always_comb begin
      if (is_lbuf) begin
         req_op = op_lbuf;
      end else if (is_sbuf) begin
         req_op = op_sbuf;
      end else begin
         req_op = op_rowsum;
      end
   end

   // handshakes
   assign accept     = nice_req_valid && nice_req_ready && (is_lbuf || is_sbuf || is_rowsum);
   assign cmd_hs     = nice_icb_cmd_valid && nice_icb_cmd_ready;
   assign run_rsp_hs = (state == st_run) && nice_icb_rsp_valid && nice_icb_rsp_ready;
   assign rsp_hs     = nice_rsp_valid && nice_rsp_ready;
   assign rsp_last   = run_rsp_hs && (rsp_cnt == cnt_end_m1);
   // last rowsum word sits in the receive register and is added on this edge
   assign rowsum_fin = (rsp_cnt == cnt_end) && buf_if.acc_busy;

   ////////////////////
   // FSM and counters
   ////////////////////
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         state   <= st_idle;
         op_r    <= op_lbuf;
         cmd_cnt <= '0;
         rsp_cnt <= '0;
         err_r   <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (accept) begin
                  state   <= st_run;
                  op_r    <= req_op;
                  cmd_cnt <= '0;
                  rsp_cnt <= '0;
                  err_r   <= 1'b0;
               end
            end
            st_run: begin
               if (cmd_hs) begin
                  cmd_cnt <= cmd_cnt + 1'b1;
               end
               if (run_rsp_hs) begin
                  rsp_cnt <= rsp_cnt + 1'b1;
               end
               // error stays set until the next instruction
               if (run_rsp_hs && nice_icb_rsp_err) begin
                  err_r <= 1'b1;
               end
               if ((op_r != op_rowsum) ? rsp_last : rowsum_fin) begin
                  state <= st_resp;
               end
            end
            st_resp: begin
               if (rsp_hs) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // next command address, loaded with rs1 and stepped per command
   always_ff @(posedge nice_clk) begin
      if (accept) begin
         addr_r <= nice_req_rs1;
      end else if (cmd_hs) begin
         addr_r <= addr_r + addr_t'(word_bytes);
      end
   end

   ////////////////////
   // outputs
   ////////////////////
   assign nice_req_ready     = (state == st_idle);
   assign nice_active        = (state != st_idle) || nice_req_valid;
   assign nice_mem_holdup    = (state == st_run);

   assign nice_icb_cmd_valid = (state == st_run) && (cmd_cnt != cnt_end);
   assign nice_icb_cmd_addr  = addr_r;
   assign nice_icb_cmd_read  = (op_r != op_sbuf);
   assign nice_icb_cmd_wdata = buf_if.rd_data;
   assign nice_icb_cmd_size  = icb_size_word;
   assign nice_icb_rsp_ready = 1'b1;

   assign nice_rsp_valid = (state == st_resp);
   assign nice_rsp_rdat  = (op_r == op_rowsum) ? buf_if.sum : '0;
   assign nice_rsp_err   = err_r;

   // row buffer strobes, indexed by response order
   assign buf_if.wr_en   = run_rsp_hs && (op_r == op_lbuf);
   assign buf_if.acc_en  = run_rsp_hs && (op_r == op_rowsum);
   assign buf_if.sum_clr = accept && (req_op == op_rowsum);
   assign buf_if.idx     = idx_w'(rsp_cnt);
   assign buf_if.rd_idx  = idx_w'(cmd_cnt);
   assign buf_if.wdata   = nice_icb_rsp_rdata;

   // command held under back-pressure, including the stored sbuf word
   assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      nice_icb_cmd_valid && !nice_icb_cmd_ready |=> nice_icb_cmd_valid
      && $stable(nice_icb_cmd_addr) && $stable(nice_icb_cmd_read)
      && $stable(nice_icb_cmd_wdata));

   // response stays up with the same data until taken
   assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      nice_rsp_valid && !nice_rsp_ready |=> nice_rsp_valid
      && $stable(nice_rsp_rdat) && $stable(nice_rsp_err));

endmodule

`default_nettype wire

// ==== verilog/nice_row_buf.sv ====
////////////////////
// nice row buffer
// row storage, rowsum receive register, accumulate and scalar sum
////////////////////
`timescale 1ns/1ps
`default_nettype none

module nice_row_buf
   import nice_pkg::*;
#(
   parameter int row_len   = 3,
   parameter int buf_depth = 4
) (
   input  logic       nice_clk,
   input  logic       nice_rst_n,
   nice_buf_if.buffer buf_if
);

   localparam int idx_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;

   word_t            rows [buf_depth];
   logic             rcv_valid;
   word_t            rcv_data;
   logic [idx_w-1:0] rcv_idx;
   word_t            sum_r;

   // a row has to fit in the buffer
   if (buf_depth < row_len) begin : g_depth_check
      $error("nice_row_buf: buf_depth smaller than row_len");
   end

   ////////////////////
   // receive register
   ////////////////////
   // rowsum word and its index wait here one cycle before the add
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         rcv_valid <= 1'b0;
      end else begin
         rcv_valid <= buf_if.acc_en;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (buf_if.acc_en) begin
         rcv_data <= buf_if.wdata;
         rcv_idx  <= buf_if.idx;
      end
   end

   ////////////////////
   // row storage
   ////////////////////
   // lbuf writes straight from the bus
   // rowsum adds the waiting word into its entry
   always_ff @(posedge nice_clk) begin
      if (buf_if.wr_en) begin
         rows[buf_if.idx] <= buf_if.wdata;
      end else if (rcv_valid) begin
         rows[rcv_idx] <= rows[rcv_idx] + rcv_data;
      end
   end

   // scalar sum is cleared when a rowsum is accepted
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         sum_r <= '0;
      end else if (buf_if.sum_clr) begin
         sum_r <= '0;
      end else if (rcv_valid) begin
         sum_r <= sum_r + rcv_data;
      end
   end

   assign buf_if.rd_data  = rows[buf_if.rd_idx];
   assign buf_if.sum      = sum_r;
   assign buf_if.acc_busy = rcv_valid;

   // strobed words always belong to the current row
   assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      (buf_if.wr_en || buf_if.acc_en) |-> (int'(buf_if.idx) < row_len));

endmodule

`default_nettype wire

// ==== verilog/nice_core.sv ====
////////////////////
// nice core top level
// custom-3 row buffer accelerator
////////////////////
`timescale 1ns/1ps
`default_nettype none

module nice_core
   import nice_pkg::*;
#(
   parameter int row_len   = 3,
   parameter int buf_depth = 4
) (
   input  logic       nice_clk,
   input  logic       nice_rst_n,
   output logic       nice_active,
   output logic       nice_mem_holdup,
   // processor request
   input  logic       nice_req_valid,
   output logic       nice_req_ready,
   input  word_t      nice_req_inst,
   input  word_t      nice_req_rs1,
   // rs2 kept for port compatibility, no instruction reads it
   input  word_t      nice_req_rs2,
   // processor response
   output logic       nice_rsp_valid,
   input  logic       nice_rsp_ready,
   output word_t      nice_rsp_rdat,
   output logic       nice_rsp_err,
   // memory command
   output logic       nice_icb_cmd_valid,
   input  logic       nice_icb_cmd_ready,
   output addr_t      nice_icb_cmd_addr,
   output logic       nice_icb_cmd_read,
   output word_t      nice_icb_cmd_wdata,
   output logic [1:0] nice_icb_cmd_size,
   // memory response
   input  logic       nice_icb_rsp_valid,
   output logic       nice_icb_rsp_ready,
   input  word_t      nice_icb_rsp_rdata,
   input  logic       nice_icb_rsp_err
);

   nice_buf_if #(.buf_depth(buf_depth)) i_buf_if ();

   // controller owns both buses and the FSM
   nice_ctrl #(
      .row_len   (row_len),
      .buf_depth (buf_depth)
   ) i_ctrl (
      .nice_clk           (nice_clk),
      .nice_rst_n         (nice_rst_n),
      .nice_active        (nice_active),
      .nice_mem_holdup    (nice_mem_holdup),
      .nice_req_valid     (nice_req_valid),
      .nice_req_ready     (nice_req_ready),
      .nice_req_inst      (nice_req_inst),
      .nice_req_rs1       (nice_req_rs1),
      .nice_rsp_valid     (nice_rsp_valid),
      .nice_rsp_ready     (nice_rsp_ready),
      .nice_rsp_rdat      (nice_rsp_rdat),
      .nice_rsp_err       (nice_rsp_err),
      .nice_icb_cmd_valid (nice_icb_cmd_valid),
      .nice_icb_cmd_ready (nice_icb_cmd_ready),
      .nice_icb_cmd_addr  (nice_icb_cmd_addr),
      .nice_icb_cmd_read  (nice_icb_cmd_read),
      .nice_icb_cmd_wdata (nice_icb_cmd_wdata),
      .nice_icb_cmd_size  (nice_icb_cmd_size),
      .nice_icb_rsp_valid (nice_icb_rsp_valid),
      .nice_icb_rsp_ready (nice_icb_rsp_ready),
      .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
      .nice_icb_rsp_err   (nice_icb_rsp_err),
      .buf_if             (i_buf_if.ctrl)
   );

   // row storage and rowsum datapath
   nice_row_buf #(
      .row_len   (row_len),
      .buf_depth (buf_depth)
   ) i_row_buf (
      .nice_clk   (nice_clk),
      .nice_rst_n (nice_rst_n),
      .buf_if     (i_buf_if.buffer)
   );

endmodule

`default_nettype wire

// ==== verification/nice_mem_model.sv ====
////////////////////
// memory model for the command/response bus
// in-order responses, stall inputs, error region
////////////////////
`timescale 1ns/1ps
`default_nettype none

module nice_mem_model
   import nice_pkg::*;
#(
   parameter int    depth    = 64,
   parameter addr_t err_base = 32'h0000_00e0
) (
   input  logic                     nice_clk,
   input  logic                     nice_rst_n,
   input  logic                     cmd_stall,
   input  logic                     rsp_stall,
   input  logic                     load_en,
   input  logic [$clog2(depth)-1:0] load_idx,
   input  word_t                    load_data,
   input  logic                     cmd_valid,
   output logic                     cmd_ready,
   input  addr_t                    cmd_addr,
   input  logic                     cmd_read,
   input  word_t                    cmd_wdata,
   output logic                     rsp_valid,
   input  logic                     rsp_ready,
   output word_t                    rsp_rdata,
   output logic                     rsp_err
);

   localparam int aw = $clog2(depth);

   word_t         mem [depth];
   // pending responses in command order
   word_t         q_data [8];
   logic          q_err [8];
   logic [3:0]    wr_ptr;
   logic [3:0]    rd_ptr;
   logic          hit_err;
   logic [aw-1:0] widx;

   assign cmd_ready = !cmd_stall;
   assign hit_err   = (cmd_addr >= err_base);
   assign widx      = cmd_addr[aw+1:2];
   assign rsp_valid = (wr_ptr != rd_ptr) && !rsp_stall;
   assign rsp_rdata = q_data[rd_ptr[2:0]];
   assign rsp_err   = q_err[rd_ptr[2:0]];

   always @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (cmd_valid && cmd_ready) begin
            wr_ptr <= wr_ptr + 4'd1;
         end
         if (rsp_valid && rsp_ready) begin
            rd_ptr <= rd_ptr + 4'd1;
         end
      end
   end

   // error region reads as zero and drops writes
   always @(posedge nice_clk) begin
      if (cmd_valid && cmd_ready) begin
         q_data[wr_ptr[2:0]] <= (cmd_read && !hit_err) ? mem[widx] : '0;
         q_err[wr_ptr[2:0]]  <= hit_err;
      end
      if (load_en) begin
         mem[load_idx] <= load_data;
      end else if (cmd_valid && cmd_ready && !cmd_read && !hit_err) begin
         mem[widx] <= cmd_wdata;
      end
   end

endmodule

`default_nettype wire

// ==== verification/nice_core_tb.sv ====
////////////////////
// nice core testbench
// table of instructions checked against a row buffer and memory model
////////////////////
`timescale 1ns/1ps
`default_nettype none

module nice_core_tb
   import nice_pkg::*;
();

   localparam int    row_len    = 3;
   localparam int    buf_depth  = 4;
   localparam int    mem_words  = 64;
   localparam addr_t err_base   = 32'h0000_00e0;
   localparam int    tmo_cycles = 200;
   localparam int    n_steps    = 10;

   // instruction kinds used in the table
   localparam logic [1:0] k_lbuf   = 2'd0;
   localparam logic [1:0] k_sbuf   = 2'd1;
   localparam logic [1:0] k_rowsum = 2'd2;
   localparam logic [1:0] k_other  = 2'd3;

   typedef struct packed {
      logic [1:0] kind;
      addr_t      rs1;
      logic       expect_rsp;
   } step_t;

   logic       nice_clk = 1'b0;
   logic       nice_rst_n;
   logic       nice_active;
   logic       nice_mem_holdup;
   logic       nice_req_valid;
   logic       nice_req_ready;
   word_t      nice_req_inst;
   word_t      nice_req_rs1;
   word_t      nice_req_rs2;
   logic       nice_rsp_valid;
   logic       nice_rsp_ready;
   word_t      nice_rsp_rdat;
   logic       nice_rsp_err;
   logic       nice_icb_cmd_valid;
   logic       nice_icb_cmd_ready;
   addr_t      nice_icb_cmd_addr;
   logic       nice_icb_cmd_read;
   word_t      nice_icb_cmd_wdata;
   logic [1:0] nice_icb_cmd_size;
   logic       nice_icb_rsp_valid;
   logic       nice_icb_rsp_ready;
   word_t      nice_icb_rsp_rdata;
   logic       nice_icb_rsp_err;
   logic       cmd_stall;
   logic       rsp_stall;
   logic       load_en;
   logic [5:0] load_idx;
   word_t      load_data;

   step_t       tbl [n_steps];
   word_t       exp_mem [mem_words];
   word_t       exp_buf [buf_depth];
   int          errors;
   logic        timed_out;
   logic [15:0] lfsr_state = 16'd45;

   always #4 nice_clk = ~nice_clk;

   nice_core #(.row_len(row_len), .buf_depth(buf_depth)) i_dut (.*);

   nice_mem_model #(.depth(mem_words), .err_base(err_base)) i_mem (
      .nice_clk  (nice_clk),
      .nice_rst_n(nice_rst_n),
      .cmd_stall (cmd_stall),
      .rsp_stall (rsp_stall),
      .load_en   (load_en),
      .load_idx  (load_idx),
      .load_data (load_data),
      .cmd_valid (nice_icb_cmd_valid),
      .cmd_ready (nice_icb_cmd_ready),
      .cmd_addr  (nice_icb_cmd_addr),
      .cmd_read  (nice_icb_cmd_read),
      .cmd_wdata (nice_icb_cmd_wdata),
      .rsp_valid (nice_icb_rsp_valid),
      .rsp_ready (nice_icb_rsp_ready),
      .rsp_rdata (nice_icb_rsp_rdata),
      .rsp_err   (nice_icb_rsp_err)
   );

   ////////////////////
   // random source
   ////////////////////
   // fibonacci lfsr with taps 16 14 13 11
   function automatic logic take_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic word_t take_bits(input int n);
      word_t v;
      int    i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[30:0], take_bit()};
      end
      return v;
   endfunction

   // bus stalls about one cycle in four
   // processor ready half the time
   always @(posedge nice_clk) begin
      cmd_stall      <= (take_bits(2) == '0);
      rsp_stall      <= (take_bits(2) == '0);
      nice_rsp_ready <= take_bit();
   end

   ////////////////////
   // reference model and checks
   ////////////////////
   function automatic word_t encode_inst(input logic [1:0] kind);
      logic [6:0] f7;
      logic [2:0] f3;
      case (kind)
         k_lbuf: begin
            f7 = funct7_lbuf;
            f3 = funct3_buf;
         end
         k_sbuf: begin
            f7 = funct7_sbuf;
            f3 = funct3_buf;
         end
         k_rowsum: begin
            f7 = funct7_rowsum;
            f3 = funct3_rowsum;
         end
         // custom-3 with an unknown funct7
         default: begin
            f7 = 7'b1000000;
            f3 = funct3_buf;
         end
      endcase
      return {f7, 5'd11, 5'd10, f3, 5'd1, opcode_custom3};
   endfunction

   // updates the buffer and memory copies and returns the expected response
   task automatic predict(input step_t s, output word_t rdat, output logic err);
      addr_t a;
      word_t d;
      int    k;
      rdat = '0;
      err  = 1'b0;
      for (k = 0; k < row_len; k++) begin
         a = s.rs1 + addr_t'(k * word_bytes);
         d = (a >= err_base) ? '0 : exp_mem[a[7:2]];
         if (a >= err_base) begin
            err = 1'b1;
         end
         case (s.kind)
            k_lbuf: exp_buf[k] = d;
            k_sbuf: begin
               if (a < err_base) begin
                  exp_mem[a[7:2]] = exp_buf[k];
               end
            end
            k_rowsum: begin
               exp_buf[k] = exp_buf[k] + d;
               rdat       = rdat + d;
            end
            default: ;
         endcase
      end
   endtask

   task automatic check_value(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic run_step(input int n);
      step_t s;
      word_t exp_rdat;
      logic  exp_err;
      word_t held_rdat;
      logic  held_err;
      logic  held;
      logic  done;
      int    k;
      int    cyc;
      s = tbl[n];
      predict(s, exp_rdat, exp_err);
      @(posedge nice_clk);
      nice_req_valid <= 1'b1;
      nice_req_inst  <= encode_inst(s.kind);
      nice_req_rs1   <= s.rs1;
      // handshake on the first edge with ready high
      cyc = 0;
      @(negedge nice_clk);
      while (!nice_req_ready && cyc < tmo_cycles) begin
         @(negedge nice_clk);
         cyc++;
      end
      if (!nice_req_ready) begin
         $display("Timeout at %0t ns: step %0d was never accepted", $time, n);
         errors++;
         timed_out = 1'b1;
         return;
      end
      check_value(word_t'(nice_active), 32'd1, $sformatf("step %0d request active", n));
      @(posedge nice_clk);
      nice_req_valid <= 1'b0;
      if (!s.expect_rsp) begin
         // dropped instruction leaves the bus and the response quiet
         repeat (12) begin
            @(negedge nice_clk);
            check_value(word_t'(nice_icb_cmd_valid), '0, $sformatf("step %0d cmd_valid", n));
            check_value(word_t'(nice_rsp_valid), '0, $sformatf("step %0d rsp_valid", n));
            check_value(word_t'(nice_active), '0, $sformatf("step %0d idle active", n));
         end
         check_value(word_t'(nice_req_ready), 32'd1, $sformatf("step %0d req_ready", n));
         return;
      end
      k    = 0;
      cyc  = 0;
      held = 1'b0;
      done = 1'b0;
      while (!done && cyc < tmo_cycles) begin
         @(negedge nice_clk);
         cyc++;
         check_value(word_t'(nice_active), 32'd1, $sformatf("step %0d busy active", n));
         check_value(word_t'(nice_icb_rsp_ready), 32'd1,
                     $sformatf("step %0d icb rsp_ready", n));
         if (nice_icb_cmd_valid) begin
            check_value(word_t'(nice_mem_holdup), 32'd1, $sformatf("step %0d holdup", n));
         end
         if (nice_rsp_valid) begin
            check_value(word_t'(nice_mem_holdup), '0, $sformatf("step %0d resp holdup", n));
         end
         if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
            check_value(nice_icb_cmd_addr, s.rs1 + addr_t'(k * word_bytes),
                        $sformatf("step %0d cmd %0d addr", n, k));
            check_value(word_t'(nice_icb_cmd_read), word_t'(s.kind != k_sbuf),
                        $sformatf("step %0d cmd %0d read", n, k));
            check_value(word_t'(nice_icb_cmd_size), word_t'(icb_size_word),
                        $sformatf("step %0d cmd %0d size", n, k));
            if (s.kind == k_sbuf) begin
               check_value(nice_icb_cmd_wdata, exp_buf[k], $sformatf("step %0d wdata %0d", n, k));
            end
            k++;
         end
         // response held under back-pressure
         if (held) begin
            check_value(word_t'(nice_rsp_valid), 32'd1, $sformatf("step %0d held valid", n));
            check_value(nice_rsp_rdat, held_rdat, $sformatf("step %0d held rdat", n));
            check_value(word_t'(nice_rsp_err), word_t'(held_err), $sformatf("step %0d held err", n));
         end
         held = 1'b0;
         if (nice_rsp_valid && nice_rsp_ready) begin
            check_value(nice_rsp_rdat, exp_rdat, $sformatf("step %0d rdat", n));
            check_value(word_t'(nice_rsp_err), word_t'(exp_err), $sformatf("step %0d err", n));
            check_value(word_t'(k), word_t'(row_len), $sformatf("step %0d command count", n));
            done = 1'b1;
         end else if (nice_rsp_valid) begin
            held      = 1'b1;
            held_rdat = nice_rsp_rdat;
            held_err  = nice_rsp_err;
         end
      end
      if (!done) begin
         $display("Timeout at %0t ns: no response for step %0d", $time, n);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      int i;
      nice_rst_n     = 1'b0;
      nice_req_valid = 1'b0;
      nice_req_inst  = '0;
      nice_req_rs1   = '0;
      nice_req_rs2   = '0;
      nice_rsp_ready = 1'b0;
      cmd_stall      = 1'b0;
      rsp_stall      = 1'b0;
      load_en        = 1'b0;
      load_idx       = '0;
      load_data      = '0;
      errors         = 0;
      timed_out      = 1'b0;
      // areas A 0x00, B 0x40, C 0x80, D 0xa0, error region from 0xe0
      tbl = '{
         '{k_other,  32'h30, 1'b0},
         '{k_lbuf,   32'h00, 1'b1},
         '{k_sbuf,   32'h40, 1'b1},
         '{k_rowsum, 32'h80, 1'b1},
         '{k_sbuf,   32'ha0, 1'b1},
         '{k_lbuf,   32'hdc, 1'b1},
         '{k_lbuf,   32'h10, 1'b1},
         '{k_rowsum, 32'h20, 1'b1},
         '{k_sbuf,   32'hc0, 1'b1},
         '{k_other,  32'h50, 1'b0}
      };
      for (i = 0; i < mem_words; i++) begin
         exp_mem[i] = take_bits(32);
      end
      repeat (5) @(posedge nice_clk);
      nice_rst_n <= 1'b1;
      @(negedge nice_clk);
      check_value(word_t'(nice_req_ready), 32'd1, "reset req_ready");
      check_value(word_t'(nice_rsp_valid), '0, "reset rsp_valid");
      check_value(word_t'(nice_icb_cmd_valid), '0, "reset cmd_valid");
      check_value(word_t'(nice_mem_holdup), '0, "reset mem_holdup");
      check_value(word_t'(nice_active), '0, "reset active");
      // preload memory through the model's load port
      for (i = 0; i < mem_words; i++) begin
         @(posedge nice_clk);
         load_en   <= 1'b1;
         load_idx  <= 6'(i);
         load_data <= exp_mem[i];
      end
      @(posedge nice_clk);
      load_en <= 1'b0;
      for (i = 0; i < n_steps && !timed_out; i++) begin
         run_step(i);
      end
      @(negedge nice_clk);
      for (i = 0; i < mem_words; i++) begin
         check_value(i_mem.mem[i], exp_mem[i], $sformatf("memory word %0d", i));
      end
      $display("nice_core_tb done, %0d errors", errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/nice_pkg.sv
verilog/nice_buf_if.sv
verilog/nice_ctrl.sv
verilog/nice_row_buf.sv
verilog/nice_core.sv
verification/nice_mem_model.sv
verification/nice_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the nice core testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module nice_core_tb \
		-f src.f --Mdir obj_dir -o nice_core_tb
	obj_dir/nice_core_tb | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
